//--- compile.f
+incdir+hdl
hdl/cdr_pkg.sv
hdl/adc_frame_reg.sv
hdl/mm_lane_pd.sv
hdl/mm_pd_combine.sv
hdl/mm_cdr.sv
hdl/cdr_top.sv
bench/tb_cdr_top.sv

//--- Makefile
VERILATOR ?= verilator
TOP       := tb_cdr_top
FILELIST  := compile.f
VFLAGS    := --binary --timing --assert -Wno-fatal -Mdir obj_dir
BIN       := obj_dir/V$(TOP)
LOG       := sim.log
SRCS      := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -qx "TB PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/tb_cdr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdr_defs.svh"

module tb_cdr_top;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int EST_W        = `CDR_NADC + 2 + `CDR_EST_SHIFT;
    // combined error saturates symmetrically
    localparam int PD_LIM       = 2 ** (`CDR_NADC + 1) - 1;
    localparam int TEST_CYCLES  = RESET_CYCLES + 40 + 30 + 100 + 100 + 24 + 100;
    localparam int TIMEOUT_NS   = (TEST_CYCLES + 200) * CLK_PERIOD;
    localparam int S_SAMPLE     = 0;
    localparam int S_WAIT       = 1;
    localparam int S_READY      = 2;

    logic clk;
    logic ext_rstb;
    cdr_pkg::adc_sample_t din [`CDR_NTI-1:0];
    cdr_pkg::pd_err_t     pd_offset;
    logic                 invert;
    logic                 ramp_clock;
    logic [`CDR_GAIN_W-1:0] kp;
    logic [`CDR_GAIN_W-1:0] ki;
    logic [`CDR_GAIN_W-1:0] kr;
    logic                 en_freq;
    logic                 en_ramp;
    logic                 en_ext;
    cdr_pkg::pi_code_t    ext_pi;
    logic                 sample_state;
    cdr_pkg::pd_err_t     phase_est;
    cdr_pkg::est_t        freq_est;
    cdr_pkg::est_t        ramp_est;
    cdr_pkg::pi_code_t    pi_ctl [`CDR_NOUT-1:0];
    logic                 freq_lvl_cross;
    logic                 wait_on_reset_b;

    // reference model state
    int     m_cur [`CDR_NTI-1:0];
    int     m_lane [`CDR_NTI-1:0];
    int     m_prev_last;
    int     m_pd_err;
    int     m_edges;
    int     m_state;
    longint m_phase;
    longint m_freq;
    longint m_prev_fu;
    longint m_rp;
    longint m_rn;
    longint m_snap_phase;
    longint m_snap_freq;
    longint m_snap_ramp;
    bit     m_rc_ff;
    bit     m_rc_sync;
    bit     m_cross;

    logic [31:0] lfsr;
    int          errors;

    cdr_top dut_i (
        .clk               (clk),
        .ext_rstb          (ext_rstb),
        .din_i             (din),
        .pd_offset_i       (pd_offset),
        .invert_i          (invert),
        .ramp_clock_i      (ramp_clock),
        .kp_i              (kp),
        .ki_i              (ki),
        .kr_i              (kr),
        .en_freq_est_i     (en_freq),
        .en_ramp_est_i     (en_ramp),
        .en_ext_pi_ctl_i   (en_ext),
        .ext_pi_ctl_i      (ext_pi),
        .sample_state_i    (sample_state),
        .phase_est_o       (phase_est),
        .freq_est_o        (freq_est),
        .ramp_est_o        (ramp_est),
        .pi_ctl_o          (pi_ctl),
        .freq_lvl_cross_o  (freq_lvl_cross),
        .wait_on_reset_b_o (wait_on_reset_b)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("TB FAILED");
        $fatal(1, "watchdog expired");
    end

    // taps 32, 22, 2, 1
    function automatic logic [31:0] next_lfsr(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic int random_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++) begin
            lfsr = next_lfsr(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        return v;
    endfunction

    function automatic int signed_random(input int n);
        int v;
        v = random_bits(n);
        if (v >= (1 << (n - 1))) begin
            v = v - (1 << n);
        end
        return v;
    endfunction

    // two's complement wrap to the estimator width
    function automatic longint wrap_est(input longint v);
        logic signed [EST_W-1:0] w;
        w = v[EST_W-1:0];
        return longint'(w);
    endfunction

    function automatic int sgn(input int v);
        return (v >= 0) ? 1 : -1;
    endfunction

    function automatic int mm_term(input int c, input int p);
        return c * sgn(p) - p * sgn(c);
    endfunction

    function automatic int combine(input int lanes [`CDR_NTI-1:0], input int offs, input bit inv);
        int sum;
        sum = 0;
        for (int k = 0; k < `CDR_NTI; k++) begin
            sum += lanes[k];
        end
        sum = (sum >>> `CDR_NTI_LOG2) + offs;
        if (sum > PD_LIM) begin
            sum = PD_LIM;
        end else if (sum < -PD_LIM) begin
            sum = -PD_LIM;
        end
        return inv ? -sum : sum;
    endfunction

    task automatic expect_equal(input longint actual, input longint expected, input string what);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH at %0t ns: %s got %0d expected %0d", $time, what, actual,
                     expected);
            $display("TB FAILED");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic clear_model();
        for (int k = 0; k < `CDR_NTI; k++) begin
            m_cur[k]  = 0;
            m_lane[k] = 0;
        end
        m_prev_last = 0;
        m_pd_err    = 0;
        m_edges     = 0;
        m_state     = S_WAIT;
        m_phase     = 0;
        m_freq      = 0;
        m_prev_fu   = 0;
        m_rp        = 0;
        m_rn        = 0;
        m_snap_phase = 0;
        m_snap_freq  = 0;
        m_snap_ramp  = 0;
        m_rc_ff     = 0;
        m_rc_sync   = 0;
        m_cross     = 0;
    endtask

    // advance the whole pipeline by one rising edge using the pre-edge state
    task automatic step_model();
        longint err;
        longint ekr;
        longint rp_upd;
        longint rn_upd;
        longint fu;
        bit     loop_on;
        loop_on = (m_edges >= `CDR_HOLD_CYCLES);
        err     = loop_on ? longint'(m_pd_err) : 0;
        ekr     = wrap_est(err <<< kr);
        rp_upd  = wrap_est(m_rp + (ramp_clock ? ekr : 0));
        rn_upd  = wrap_est(m_rn + (ramp_clock ? 0 : ekr));
        fu      = wrap_est(wrap_est(err <<< ki) + (m_rc_sync ? m_rp : -m_rn));

        case (m_state)
            S_SAMPLE: begin
                m_snap_phase = m_phase >>> `CDR_EST_SHIFT;
                m_snap_freq  = fu;
                m_snap_ramp  = ramp_clock ? rp_upd : rn_upd;
                m_state      = S_WAIT;
            end
            S_WAIT: begin
                if (!sample_state) begin
                    m_state = S_READY;
                end
            end
            default: begin
                if (sample_state) begin
                    m_state = S_SAMPLE;
                end
            end
        endcase

        m_cross = (fu - m_prev_fu) > 0;
        if (loop_on) begin
            m_phase   = wrap_est(m_phase + wrap_est(err <<< kp) + m_freq);
            m_freq    = en_freq ? wrap_est(m_freq + fu) : m_freq;
            m_prev_fu = fu;
            m_rp      = en_ramp ? rp_upd : 0;
            m_rn      = en_ramp ? rn_upd : 0;
        end
        m_rc_sync = m_rc_ff;
        m_rc_ff   = ramp_clock;
        m_edges++;

        // front end runs back to front so each stage sees the old value
        m_pd_err = combine(m_lane, int'(pd_offset), invert);
        for (int k = 0; k < `CDR_NTI; k++) begin
            m_lane[k] = mm_term(m_cur[k], (k == 0) ? m_prev_last : m_cur[k-1]);
        end
        m_prev_last = m_cur[`CDR_NTI-1];
        for (int k = 0; k < `CDR_NTI; k++) begin
            m_cur[k] = int'(din[k]);
        end
    endtask

    task automatic compare_outputs();
        longint exp_pi;
        exp_pi = en_ext ? longint'(ext_pi) : ((m_phase >>> `CDR_EST_SHIFT) & 255);
        for (int j = 0; j < `CDR_NOUT; j++) begin
            expect_equal(longint'(pi_ctl[j]), exp_pi, $sformatf("pi_ctl_o[%0d]", j));
        end
        expect_equal(longint'(freq_lvl_cross), longint'(m_cross), "freq_lvl_cross_o");
        expect_equal(longint'(wait_on_reset_b), longint'(m_edges >= `CDR_HOLD_CYCLES),
                     "wait_on_reset_b_o");
        expect_equal(longint'(phase_est), m_snap_phase, "phase_est_o");
        expect_equal(longint'(freq_est), m_snap_freq, "freq_est_o");
        expect_equal(longint'(ramp_est), m_snap_ramp, "ramp_est_o");
    endtask

    // inputs change and outputs are checked 1 ns after the edge
    task automatic cycle();
        @(posedge clk);
        #1;
        step_model();
        compare_outputs();
    endtask

    task automatic drive_random_frame(input int nbits);
        for (int k = 0; k < `CDR_NTI; k++) begin
            din[k] = cdr_pkg::adc_sample_t'(signed_random(nbits));
        end
    endtask

    task automatic hold_after_reset();
        for (int j = 0; j < `CDR_NOUT; j++) begin
            expect_equal(longint'(pi_ctl[j]), 0, "pi_ctl_o after reset");
        end
        expect_equal(longint'(freq_lvl_cross), 0, "freq_lvl_cross_o after reset");
        expect_equal(longint'(wait_on_reset_b), 0, "wait_on_reset_b_o after reset");
        expect_equal(longint'(phase_est), 0, "phase_est_o after reset");
        expect_equal(longint'(freq_est), 0, "freq_est_o after reset");
        expect_equal(longint'(ramp_est), 0, "ramp_est_o after reset");
        for (int i = 1; i <= 40; i++) begin
            drive_random_frame(8);
            cycle();
            expect_equal(longint'(wait_on_reset_b), longint'(i >= `CDR_HOLD_CYCLES),
                         "wait_on_reset_b_o edge count");
            if (i <= `CDR_HOLD_CYCLES) begin
                expect_equal(longint'(pi_ctl[0]), 0, "pi_ctl_o during reset hold");
            end
        end
    endtask

    task automatic pi_override();
        en_ext = 1'b1;
        for (int i = 0; i < 20; i++) begin
            ext_pi = cdr_pkg::pi_code_t'(random_bits(`CDR_NPI));
            drive_random_frame(8);
            cycle();
            for (int j = 0; j < `CDR_NOUT; j++) begin
                expect_equal(longint'(pi_ctl[j]), longint'(ext_pi), "pi_ctl_o override");
            end
        end
        en_ext = 1'b0;
        for (int i = 0; i < 10; i++) begin
            drive_random_frame(8);
            cycle();
        end
    endtask

    task automatic proportional_loop();
        en_freq = 1'b0;
        en_ramp = 1'b0;
        kp      = 3;
        for (int i = 0; i < 100; i++) begin
            drive_random_frame(8);
            cycle();
        end
    endtask

    // a flat frame has no timing error so only the offset drives the loop
    task automatic invert_and_offset();
        for (int k = 0; k < `CDR_NTI; k++) begin
            din[k] = 8'sd40;
        end
        invert    = 1'b1;
        pd_offset = 10'sd6;
        kp        = 4;
        for (int i = 0; i < 40; i++) begin
            cycle();
        end
        en_freq = 1'b1;
        ki      = 2;
        for (int i = 0; i < 60; i++) begin
            cycle();
        end
        invert    = 1'b0;
        pd_offset = '0;
    endtask

    task automatic ramp_snapshot();
        en_ramp = 1'b1;
        en_freq = 1'b1;
        kp      = 2;
        ki      = 1;
        kr      = 1;
        for (int i = 0; i < 24; i++) begin
            // two requests of a low phase followed by a long high phase
            sample_state = !((i >= 4 && i < 7) || (i >= 15 && i < 18));
            ramp_clock   = ((i / 4) % 2) == 1;
            drive_random_frame(5);
            cycle();
        end
        en_ramp    = 1'b0;
        ramp_clock = 1'b0;
    endtask

    task automatic freq_crossing();
        int ones;
        ones    = 0;
        en_freq = 1'b1;
        ki      = 3;
        for (int i = 0; i < 100; i++) begin
            drive_random_frame(8);
            cycle();
            ones += int'(freq_lvl_cross);
        end
        expect_equal(longint'(ones > 0 && ones < 100), 1, "freq_lvl_cross_o toggling");
    endtask

    initial begin
        errors       = 0;
        lfsr         = 32'h6003661a;
        ext_rstb     = 1'b0;
        for (int k = 0; k < `CDR_NTI; k++) begin
            din[k] = '0;
        end
        pd_offset    = '0;
        invert       = 1'b0;
        ramp_clock   = 1'b0;
        kp           = 2;
        ki           = 0;
        kr           = 0;
        en_freq      = 1'b0;
        en_ramp      = 1'b0;
        en_ext       = 1'b0;
        ext_pi       = '0;
        sample_state = 1'b1;
        clear_model();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        ext_rstb = 1'b1;

        hold_after_reset();
        pi_override();
        proportional_loop();
        invert_and_offset();
        ramp_snapshot();
        freq_crossing();

        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- hdl/cdr_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdr_defs.svh"

module cdr_top (
    input  wire logic                    clk,
    input  wire logic                    ext_rstb,
    input  wire cdr_pkg::adc_sample_t    din_i [`CDR_NTI-1:0],
    input  wire cdr_pkg::pd_err_t        pd_offset_i,
    input  wire logic                    invert_i,
    input  wire logic                    ramp_clock_i,
    input  wire logic [`CDR_GAIN_W-1:0]  kp_i,
    input  wire logic [`CDR_GAIN_W-1:0]  ki_i,
    input  wire logic [`CDR_GAIN_W-1:0]  kr_i,
    input  wire logic                    en_freq_est_i,
    input  wire logic                    en_ramp_est_i,
    input  wire logic                    en_ext_pi_ctl_i,
    input  wire cdr_pkg::pi_code_t       ext_pi_ctl_i,
    input  wire logic                    sample_state_i,
    output cdr_pkg::pd_err_t             phase_est_o,
    output cdr_pkg::est_t                freq_est_o,
    output cdr_pkg::est_t                ramp_est_o,
    output cdr_pkg::pi_code_t            pi_ctl_o [`CDR_NOUT-1:0],
    output logic                         freq_lvl_cross_o,
    output logic                         wait_on_reset_b_o
);

    cdr_pkg::adc_sample_t cur     [`CDR_NTI-1:0];
    cdr_pkg::adc_sample_t prev_last;
    cdr_pkg::lane_err_t   lane_err [`CDR_NTI-1:0];
    cdr_pkg::pd_err_t     pd_err;

    adc_frame_reg frame_reg_i (
        .clk         (clk),
        .ext_rstb    (ext_rstb),
        .din_i       (din_i),
        .cur_o       (cur),
        .prev_last_o (prev_last)
    );

    // lane 0 takes its predecessor from the previous frame
    for (genvar k = 0; k < `CDR_NTI; k++) begin : g_lane
        if (k == 0) begin : g_first
            mm_lane_pd lane_i (
                .clk      (clk),
                .ext_rstb (ext_rstb),
                .cur_i    (cur[k]),
                .prev_i   (prev_last),
                .err_o    (lane_err[k])
            );
        end else begin : g_rest
            mm_lane_pd lane_i (
                .clk      (clk),
                .ext_rstb (ext_rstb),
                .cur_i    (cur[k]),
                .prev_i   (cur[k-1]),
                .err_o    (lane_err[k])
            );
        end
    end

    mm_pd_combine combine_i (
        .clk         (clk),
        .ext_rstb    (ext_rstb),
        .lane_err_i  (lane_err),
        .pd_offset_i (pd_offset_i),
        .invert_i    (invert_i),
        .pd_err_o    (pd_err)
    );

    mm_cdr cdr_i (
        .clk               (clk),
        .ext_rstb          (ext_rstb),
        .pd_err_i          (pd_err),
        .ramp_clock_i      (ramp_clock_i),
        .kp_i              (kp_i),
        .ki_i              (ki_i),
        .kr_i              (kr_i),
        .en_freq_est_i     (en_freq_est_i),
        .en_ramp_est_i     (en_ramp_est_i),
        .en_ext_pi_ctl_i   (en_ext_pi_ctl_i),
        .ext_pi_ctl_i      (ext_pi_ctl_i),
        .sample_state_i    (sample_state_i),
        .phase_est_o       (phase_est_o),
        .freq_est_o        (freq_est_o),
        .ramp_est_o        (ramp_est_o),
        .pi_ctl_o          (pi_ctl_o),
        .freq_lvl_cross_o  (freq_lvl_cross_o),
        .wait_on_reset_b_o (wait_on_reset_b_o)
    );

endmodule

`default_nettype wire

//--- hdl/mm_cdr.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdr_defs.svh"

module mm_cdr (
    input  wire logic                    clk,
    input  wire logic                    ext_rstb,
    input  wire cdr_pkg::pd_err_t        pd_err_i,
    input  wire logic                    ramp_clock_i,
    input  wire logic [`CDR_GAIN_W-1:0]  kp_i,
    input  wire logic [`CDR_GAIN_W-1:0]  ki_i,
    input  wire logic [`CDR_GAIN_W-1:0]  kr_i,
    input  wire logic                    en_freq_est_i,
    input  wire logic                    en_ramp_est_i,
    input  wire logic                    en_ext_pi_ctl_i,
    input  wire cdr_pkg::pi_code_t       ext_pi_ctl_i,
    input  wire logic                    sample_state_i,
    output cdr_pkg::pd_err_t             phase_est_o,
    output cdr_pkg::est_t                freq_est_o,
    output cdr_pkg::est_t                ramp_est_o,
    output cdr_pkg::pi_code_t            pi_ctl_o [`CDR_NOUT-1:0],
    output logic                         freq_lvl_cross_o,
    output logic                         wait_on_reset_b_o
);

    localparam int EST_W  = `CDR_NADC + 2 + `CDR_EST_SHIFT;
    localparam int HOLD_W = $clog2(`CDR_HOLD_CYCLES);
    localparam logic [HOLD_W-1:0] HOLD_LAST = HOLD_W'(`CDR_HOLD_CYCLES - 1);

    logic [HOLD_W-1:0] hold_cnt_q;

    logic ramp_clock_ff;
    logic ramp_clock_sync;

    cdr_pkg::pd_err_t phase_error;
    cdr_pkg::est_t    err_ext;
    cdr_pkg::est_t    err_kr;

    cdr_pkg::est_t phase_est_q;
    cdr_pkg::est_t phase_est_d;
    cdr_pkg::est_t freq_est_q;
    cdr_pkg::est_t freq_est_d;
    cdr_pkg::est_t freq_update;
    cdr_pkg::est_t prev_freq_update_q;
    cdr_pkg::est_t ramp_pls_q;
    cdr_pkg::est_t ramp_pls_upd;
    cdr_pkg::est_t ramp_pls_d;
    cdr_pkg::est_t ramp_neg_q;
    cdr_pkg::est_t ramp_neg_upd;
    cdr_pkg::est_t ramp_neg_d;

    // one extra bit so the difference of two updates cannot wrap
    logic signed [EST_W:0] freq_diff;

    cdr_pkg::pd_err_t       phase_est_out;
    cdr_pkg::pi_code_t      pi_code;
    cdr_pkg::sampler_state_t sampler_state;

    // hold counter, wait flag rises on the last hold edge and then sticks
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            hold_cnt_q        <= '0;
            wait_on_reset_b_o <= 1'b0;
        end else begin
            if (hold_cnt_q != HOLD_LAST) begin
                hold_cnt_q <= hold_cnt_q + 1'b1;
            end
            wait_on_reset_b_o <= (hold_cnt_q == HOLD_LAST);
        end
    end

    always_comb begin
        phase_error = wait_on_reset_b_o ? pd_err_i : '0;
        err_ext     = cdr_pkg::est_t'(phase_error);
        err_kr      = err_ext <<< kr_i;

        // ramp halves integrate on the raw ramp clock level
        ramp_pls_upd = ramp_pls_q + (ramp_clock_i ? err_kr : '0);
        ramp_neg_upd = ramp_neg_q + (ramp_clock_i ? '0 : err_kr);
        ramp_pls_d   = en_ramp_est_i ? ramp_pls_upd : '0;
        ramp_neg_d   = en_ramp_est_i ? ramp_neg_upd : '0;

        // frequency path sees the synchronized ramp clock
        freq_update = (err_ext <<< ki_i) + (ramp_clock_sync ? ramp_pls_q : -ramp_neg_q);
        freq_est_d  = freq_est_q + (en_freq_est_i ? freq_update : '0);
        freq_diff   = {freq_update[EST_W-1], freq_update}
                    - {prev_freq_update_q[EST_W-1], prev_freq_update_q};

        phase_est_d = phase_est_q + (err_ext <<< kp_i) + freq_est_q;

        // integer part of the phase estimate
        phase_est_out = cdr_pkg::pd_err_t'(phase_est_q >>> `CDR_EST_SHIFT);
        pi_code       = cdr_pkg::pi_code_t'(phase_est_out);
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            phase_est_q        <= '0;
            freq_est_q         <= '0;
            prev_freq_update_q <= '0;
            ramp_pls_q         <= '0;
            ramp_neg_q         <= '0;
            ramp_clock_ff      <= 1'b0;
            ramp_clock_sync    <= 1'b0;
        end else begin
            phase_est_q        <= wait_on_reset_b_o ? phase_est_d : '0;
            freq_est_q         <= wait_on_reset_b_o ? freq_est_d : '0;
            prev_freq_update_q <= wait_on_reset_b_o ? freq_update : '0;
            ramp_pls_q         <= wait_on_reset_b_o ? ramp_pls_d : '0;
            ramp_neg_q         <= wait_on_reset_b_o ? ramp_neg_d : '0;
            ramp_clock_ff      <= ramp_clock_i;
            ramp_clock_sync    <= ramp_clock_ff;
        end
    end

    // all PI outputs carry the same code
    always_comb begin
        for (int i = 0; i < `CDR_NOUT; i++) begin
            pi_ctl_o[i] = en_ext_pi_ctl_i ? ext_pi_ctl_i : pi_code;
        end
    end

    // snapshot FSM, needs the request low then high before each capture
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            phase_est_o   <= '0;
            freq_est_o    <= '0;
            ramp_est_o    <= '0;
            sampler_state <= cdr_pkg::WAIT;
        end else begin
            case (sampler_state)
                cdr_pkg::SAMPLE: begin
                    phase_est_o   <= phase_est_out;
                    freq_est_o    <= freq_update;
                    ramp_est_o    <= ramp_clock_i ? ramp_pls_upd : ramp_neg_upd;
                    sampler_state <= cdr_pkg::WAIT;
                end
                cdr_pkg::WAIT: begin
                    sampler_state <= sample_state_i ? cdr_pkg::WAIT : cdr_pkg::READY;
                end
                cdr_pkg::READY: begin
                    sampler_state <= sample_state_i ? cdr_pkg::SAMPLE : cdr_pkg::READY;
                end
                default: begin
                    sampler_state <= cdr_pkg::WAIT;
                end
            endcase
        end
    end

    // rising frequency update flag
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            freq_lvl_cross_o <= 1'b0;
        end else begin
            freq_lvl_cross_o <= (freq_diff > 0);
        end
    end

    a_sampler_legal: assert property (@(posedge clk) disable iff (!ext_rstb)
        sampler_state inside {cdr_pkg::SAMPLE, cdr_pkg::WAIT, cdr_pkg::READY});

    a_wait_sticky: assert property (@(posedge clk) disable iff (!ext_rstb)
        wait_on_reset_b_o |=> wait_on_reset_b_o);

endmodule

`default_nettype wire

//--- hdl/mm_pd_combine.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdr_defs.svh"

module mm_pd_combine (
    input  wire logic                 clk,
    input  wire logic                 ext_rstb,
    input  wire cdr_pkg::lane_err_t   lane_err_i [`CDR_NTI-1:0],
    input  wire cdr_pkg::pd_err_t     pd_offset_i,
    input  wire logic                 invert_i,
    output cdr_pkg::pd_err_t          pd_err_o
);

    localparam int SUM_W = `CDR_NADC + 1 + `CDR_NTI_LOG2;
    localparam int TOT_W = SUM_W + 1;
    localparam int PD_W  = `CDR_NADC + 2;
    // symmetric limit, so the polarity flip after saturation cannot wrap
    localparam int PD_MAX = 2 ** (PD_W - 1) - 1;

    logic signed [SUM_W-1:0] lane_sum;
    logic signed [SUM_W-1:0] lane_avg;
    logic signed [TOT_W-1:0] total;
    cdr_pkg::pd_err_t        sat;
    cdr_pkg::pd_err_t        err_d;

    always_comb begin
        lane_sum = '0;
        for (int i = 0; i < `CDR_NTI; i++) begin
            lane_sum = lane_sum + lane_err_i[i];
        end
        // divide by the lane count
        lane_avg = lane_sum >>> `CDR_NTI_LOG2;
        total    = lane_avg + pd_offset_i;

        if (total > PD_MAX) begin
            sat = cdr_pkg::pd_err_t'(PD_MAX);
        end else if (total < -PD_MAX) begin
            sat = cdr_pkg::pd_err_t'(-PD_MAX);
        end else begin
            sat = total[PD_W-1:0];
        end

        err_d = invert_i ? -sat : sat;
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            pd_err_o <= '0;
        end else begin
            pd_err_o <= err_d;
        end
    end

    // the most negative code must never reach the loop filter
    a_pd_sat: assert property (@(posedge clk) disable iff (!ext_rstb)
        (pd_err_o <= PD_MAX) && (pd_err_o >= -PD_MAX));

endmodule

`default_nettype wire

//--- hdl/mm_lane_pd.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdr_defs.svh"

module mm_lane_pd (
    input  wire logic                  clk,
    input  wire logic                  ext_rstb,
    input  wire cdr_pkg::adc_sample_t  cur_i,
    input  wire cdr_pkg::adc_sample_t  prev_i,
    output cdr_pkg::lane_err_t         err_o
);

    localparam int MAX_MAG = 2 ** (`CDR_NADC - 1);

    // one bit wider so that negating the most negative sample fits
    cdr_pkg::lane_err_t cur_x;
    cdr_pkg::lane_err_t prev_x;
    cdr_pkg::lane_err_t term_a;
    cdr_pkg::lane_err_t term_b;
    cdr_pkg::lane_err_t err_d;

    // err = cur * sgn(prev) - prev * sgn(cur), sign of zero is +1
    always_comb begin
        cur_x  = cdr_pkg::lane_err_t'(cur_i);
        prev_x = cdr_pkg::lane_err_t'(prev_i);
        term_a = prev_i[`CDR_NADC-1] ? -cur_x : cur_x;
        term_b = cur_i[`CDR_NADC-1] ? -prev_x : prev_x;
        err_d  = term_a - term_b;
    end

    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            err_o <= '0;
        end else begin
            err_o <= err_d;
        end
    end

    function automatic int mag(input int v);
        return (v < 0) ? -v : v;
    endfunction

    // registered term is bounded by the sample pair one cycle earlier,
    // and so never more than twice the largest sample magnitude
    a_err_bound: assert property (@(posedge clk) disable iff (!ext_rstb)
        (mag(int'(err_o)) <= mag(int'($past(cur_i))) + mag(int'($past(prev_i))))
        && (mag(int'(err_o)) <= 2 * MAX_MAG));

endmodule

`default_nettype wire

//--- hdl/adc_frame_reg.sv
`timescale 1ns/1ps
`default_nettype none

`include "cdr_defs.svh"

module adc_frame_reg (
    input  wire logic                  clk,
    input  wire logic                  ext_rstb,
    input  wire cdr_pkg::adc_sample_t  din_i [`CDR_NTI-1:0],
    output cdr_pkg::adc_sample_t       cur_o [`CDR_NTI-1:0],
    output cdr_pkg::adc_sample_t       prev_last_o
);

    // the frame is captured every cycle, there is no valid qualifier.
    // prev_last_o holds the newest sample of the frame before cur_o,
    // which is what lane 0 needs as its predecessor
    always_ff @(posedge clk or negedge ext_rstb) begin
        if (!ext_rstb) begin
            for (int i = 0; i < `CDR_NTI; i++) begin
                cur_o[i] <= '0;
            end
            prev_last_o <= '0;
        end else begin
            for (int i = 0; i < `CDR_NTI; i++) begin
                cur_o[i] <= din_i[i];
            end
            // last index is the latest sample in time
            prev_last_o <= cur_o[`CDR_NTI-1];
        end
    end

endmodule

`default_nettype wire

//--- hdl/cdr_pkg.sv
`default_nettype none

`include "cdr_defs.svh"

package cdr_pkg;

    // raw signed adc sample
    typedef logic signed [`CDR_NADC-1:0] adc_sample_t;

    // one lane's mueller-muller term, one bit of growth
    typedef logic signed [`CDR_NADC:0] lane_err_t;

    // combined phase error after scaling and offset
    typedef logic signed [`CDR_NADC+1:0] pd_err_t;

    // estimator word, phase error width plus fractional bits
    typedef logic signed [`CDR_NADC+1+`CDR_EST_SHIFT:0] est_t;

    // phase interpolator code
    typedef logic [`CDR_NPI-1:0] pi_code_t;

    // snapshot sampler states
    typedef enum logic [1:0] {
        SAMPLE,
        WAIT,
        READY
    } sampler_state_t;

endpackage

`default_nettype wire

//--- hdl/cdr_defs.svh
`ifndef CDR_DEFS_SVH
`define CDR_DEFS_SVH

// adc sample width
`define CDR_NADC 8

// interleave factor, one phase detector lane per sample
`define CDR_NTI 4
`define CDR_NTI_LOG2 2

// phase interpolator code width and number of PI outputs
`define CDR_NPI 8
`define CDR_NOUT 2

// fractional bits carried below the phase estimate
`define CDR_EST_SHIFT 12

// kp, ki and kr are plain left-shift amounts
`define CDR_GAIN_W 4

// loop stays frozen this many cycles after reset release
`define CDR_HOLD_CYCLES 32

`endif
